// ==== uart_settings.svh ====
/*
    UART build-time settings
    Clock frequency, baud rate, derived clocks per bit, parity sense
*/
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

`define UART_CLK_FREQ     24000000                          // System clock in Hz
`define UART_BAUD_RATE    2400000                           // Line bit rate
`define UART_CLKS_PER_BIT (`UART_CLK_FREQ / `UART_BAUD_RATE) // Whole clocks per bit

// Parity sense, 0 even and 1 odd
`define UART_PARITY_ODD   1'b0

`endif

// ==== uart_pkg.sv ====
/*
    UART shared types
    Host opcode enum, transmitter and receiver FSM state enums
*/
`default_nettype none

package uart_pkg;

    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,  // Idle slot
        OP_SEND  = 2'd1,  // Launch one frame
        OP_POP   = 2'd2,  // Read head of RX FIFO
        OP_CLEAR = 2'd3   // Drop sticky error flags
    } host_op_t;

    typedef enum logic [1:0] {
        ST_IDLE,   // Line held high
        ST_SHIFT,  // Start, data and parity bits
        ST_STOP    // Final stop bit
    } tx_state_t;

    typedef enum logic [2:0] {
        RS_IDLE,    // Waiting for falling edge
        RS_START,   // Confirming start at mid-bit
        RS_DATA,    // Eight data samples
        RS_PARITY,  // Parity sample
        RS_STOP     // Stop sample, then report
    } rx_state_t;

endpackage

`default_nettype wire

// ==== uart_if.sv ====
/*
    UART internal bundles
    rx_frame_if  receiver result to FIFO and status logic
    rx_fifo_if   host side of the receive FIFO
*/
`timescale 1ns/1ps
`default_nettype none

interface rx_frame_if;
    logic [7:0] data;        // Received byte
    logic       valid;       // One-cycle strobe per frame
    logic       parity_err;  // Qualified by valid
    logic       frame_err;   // Stop bit low, qualified by valid

    modport src         (output data, valid, parity_err, frame_err);
    modport fifo_sink   (input data, valid);
    modport status_sink (input valid, parity_err, frame_err);
endinterface

interface rx_fifo_if;
    logic       pop;       // Host read request
    logic [7:0] rdata;     // Head entry
    logic       empty;     // No bytes stored
    logic       overflow;  // Pulse on dropped push

    modport store (input pop, output rdata, empty, overflow);
    modport host  (output pop, input rdata, empty, overflow);
endinterface

`default_nettype wire

// ==== uart_tx.sv ====
/*
    UART transmitter
    Latches byte and parity on start, shifts out an 11-bit frame
    Start, 8 data LSB first, parity, stop at CLKS_PER_BIT each
*/
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module uart_tx (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       tx,
    output logic       tx_busy
);
    import uart_pkg::*;

    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int CW  = $clog2(CPB);

    tx_state_t     state;
    logic [CW-1:0] clk_cnt;   // Clocks into current bit
    logic [3:0]    bit_idx;   // Bits done in ST_SHIFT
    logic [10:0]   shift_q;   // Frame, LSB on the line
    logic          parity;
    logic          bit_done;

    assign parity   = ^tx_data ^ `UART_PARITY_ODD;  // Even XOR, flipped for odd
    assign bit_done = (clk_cnt == CW'(CPB - 1));    // Last clock of a bit
    assign tx       = shift_q[0];                   // Registered line driver
    assign tx_busy  = (state != ST_IDLE);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= ST_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            shift_q <= '1;                           // Line idles high
        end
        else
        begin
            unique case (state)
                ST_IDLE:
                begin
                    if (tx_start)
                    begin
                        shift_q <= {1'b1, parity, tx_data, 1'b0};  // Stop, par, data, start
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= ST_SHIFT;
                    end
                end
                ST_SHIFT:
                begin
                    if (bit_done)
                    begin
                        clk_cnt <= '0;
                        shift_q <= {1'b1, shift_q[10:1]};  // Refill with idle level
                        bit_idx <= bit_idx + 4'd1;
                        if (bit_idx == 4'd9)
                            state <= ST_STOP;              // Parity just finished
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                ST_STOP:
                begin
                    if (bit_done)
                    begin
                        clk_cnt <= '0;
                        state   <= ST_IDLE;                // Busy drops next cycle
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Host side must hold off while a frame is on the line
    a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
        tx_start |-> !tx_busy);

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
/*
    UART receiver
    Two-flop sync, falling-edge start detect, mid-bit sampling
    Parity and stop checks, one valid strobe per completed frame
*/
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module uart_rx (
    input  logic           clk,
    input  logic           reset,
    input  logic           rx,
    rx_frame_if.src        frame
);
    import uart_pkg::*;

    localparam int CPB  = `UART_CLKS_PER_BIT;
    localparam int HALF = CPB / 2;
    localparam int CW   = $clog2(CPB);

    rx_state_t     state;
    logic          rx_meta;    // First sync stage
    logic          rx_sync;    // Safe to use
    logic          rx_last;    // For edge detect
    logic          fall;
    logic [CW-1:0] clk_cnt;
    logic [2:0]    bit_idx;    // Data bit being sampled
    logic [7:0]    data_sr;    // Shifts in LSB first
    logic          par_bit;    // Sampled parity
    logic          par_calc;
    logic          bit_mid;

    assign fall     = rx_last & ~rx_sync;
    assign bit_mid  = (clk_cnt == CW'(CPB - 1));      // Full bit after previous middle
    assign par_calc = ^data_sr ^ `UART_PARITY_ODD;
    assign frame.data = data_sr;                      // Stable while valid is high

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state            <= RS_IDLE;
            clk_cnt          <= '0;
            bit_idx          <= '0;
            frame.valid      <= 1'b0;
            frame.parity_err <= 1'b0;
            frame.frame_err  <= 1'b0;
        end
        else
        begin
            frame.valid <= 1'b0;                      // Strobe by default
            clk_cnt     <= clk_cnt + 1'b1;
            unique case (state)
                RS_IDLE:
                begin
                    clk_cnt <= '0;
                    if (fall)
                        state <= RS_START;
                end
                RS_START:
                begin
                    if (clk_cnt == CW'(HALF - 1))
                    begin
                        clk_cnt <= '0;                // Realign on mid start
                        bit_idx <= '0;
                        state   <= rx_sync ? RS_IDLE : RS_DATA;  // High again means glitch
                    end
                end
                RS_DATA:
                begin
                    if (bit_mid)
                    begin
                        clk_cnt <= '0;
                        data_sr <= {rx_sync, data_sr[7:1]};
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7)
                            state <= RS_PARITY;
                    end
                end
                RS_PARITY:
                begin
                    if (bit_mid)
                    begin
                        clk_cnt <= '0;
                        par_bit <= rx_sync;
                        state   <= RS_STOP;
                    end
                end
                RS_STOP:
                begin
                    if (bit_mid)
                    begin
                        frame.valid      <= 1'b1;     // Reported even with errors
                        frame.parity_err <= (par_bit != par_calc);
                        frame.frame_err  <= ~rx_sync; // Stop must be high
                        state            <= RS_IDLE;
                    end
                end
                default: state <= RS_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rx_fifo.sv ====
/*
    Receive FIFO
    Four-entry circular byte buffer, push on frame strobe
    Drops the byte and pulses overflow when full
*/
`timescale 1ns/1ps
`default_nettype none

module rx_fifo (
    input  logic          clk,
    input  logic          reset,
    rx_frame_if.fifo_sink frame,
    rx_fifo_if.store      host
);
    logic [7:0] mem [4];      // Payload storage
    logic [1:0] wr_ptr;
    logic [1:0] rd_ptr;
    logic [2:0] count;        // 0 to 4 entries
    logic       full;
    logic       do_push;
    logic       do_pop;

    assign full       = (count == 3'd4);
    assign do_push    = frame.valid & ~full;
    assign do_pop     = host.pop & ~host.empty;
    assign host.empty = (count == 3'd0);
    assign host.rdata = mem[rd_ptr];      // Head byte, no read latency

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= frame.data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            host.overflow <= 1'b0;
        end
        else
        begin
            host.overflow <= frame.valid & full;   // New byte lost
            if (do_push)
                wr_ptr <= wr_ptr + 2'd1;
            if (do_pop)
                rd_ptr <= rd_ptr + 2'd1;
            count <= count + {2'b00, do_push} - {2'b00, do_pop};
        end
    end

    a_count_max: assert property (@(posedge clk) disable iff (reset)
        count <= 3'd4);

endmodule

`default_nettype wire

// ==== uart_ctrl.sv ====
/*
    Host command decoder
    Send launch gated by tx_busy, FIFO pop with registered read data
    Sticky parity, framing and overrun flags cleared by OP_CLEAR
*/
`timescale 1ns/1ps
`default_nettype none

module uart_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  uart_pkg::host_op_t op,
    input  logic               op_valid,
    input  logic [7:0]         wdata,
    output logic [7:0]         rdata,
    output logic               rdata_valid,
    output logic               parity_err,
    output logic               frame_err,
    output logic               overrun,
    output logic               rx_empty,
    output logic [7:0]         tx_data,
    output logic               tx_start,
    input  logic               tx_busy,
    rx_frame_if.status_sink    frame,
    rx_fifo_if.host            fifo
);
    import uart_pkg::*;

    logic do_clear;
    logic set_par;
    logic set_frm;

    always_comb
    begin
        tx_start = 1'b0;
        fifo.pop = 1'b0;
        do_clear = 1'b0;
        if (op_valid)
        begin
            unique case (op)
                OP_SEND:  tx_start = ~tx_busy;      // Dropped while busy
                OP_POP:   fifo.pop = ~fifo.empty;   // Empty pop ignored
                OP_CLEAR: do_clear = 1'b1;
                default:  ;                         // OP_NOP
            endcase
        end
    end

    assign tx_data  = wdata;                        // Captured by TX on start
    assign rx_empty = fifo.empty;
    assign set_par  = frame.valid & frame.parity_err;
    assign set_frm  = frame.valid & frame.frame_err;

    always_ff @(posedge clk)
    begin
        if (fifo.pop)
            rdata <= fifo.rdata;                    // Head byte before pointer moves
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rdata_valid <= 1'b0;
            parity_err  <= 1'b0;
            frame_err   <= 1'b0;
            overrun     <= 1'b0;
        end
        else
        begin
            rdata_valid <= fifo.pop;
            // A set in the clear cycle survives
            parity_err  <= set_par | (parity_err & ~do_clear);
            frame_err   <= set_frm | (frame_err & ~do_clear);
            overrun     <= fifo.overflow | (overrun & ~do_clear);
        end
    end

endmodule

`default_nettype wire

// ==== uart_top.sv ====
/*
    UART top level
    Host command port, serial rx/tx, status flags
    Control, transmitter, receiver and RX FIFO instances
*/
`timescale 1ns/1ps
`default_nettype none

module uart_top (
    input  logic               clk,
    input  logic               reset,
    input  uart_pkg::host_op_t op,
    input  logic               op_valid,
    input  logic [7:0]         wdata,
    output logic [7:0]         rdata,
    output logic               rdata_valid,
    output logic               tx_busy,
    output logic               rx_empty,
    output logic               parity_err,
    output logic               frame_err,
    output logic               overrun,
    input  logic               rx,
    output logic               tx
);
    logic [7:0] tx_data;     // Host byte to transmitter
    logic       tx_start;    // Launch strobe

    rx_frame_if u_frame_if ();
    rx_fifo_if  u_fifo_if ();

    uart_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .op          (op),
        .op_valid    (op_valid),
        .wdata       (wdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .parity_err  (parity_err),
        .frame_err   (frame_err),
        .overrun     (overrun),
        .rx_empty    (rx_empty),
        .tx_data     (tx_data),
        .tx_start    (tx_start),
        .tx_busy     (tx_busy),
        .frame       (u_frame_if.status_sink),
        .fifo        (u_fifo_if.host)
    );

    uart_tx u_tx (
        .clk      (clk),
        .reset    (reset),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

    uart_rx u_rx (
        .clk   (clk),
        .reset (reset),
        .rx    (rx),
        .frame (u_frame_if.src)
    );

    rx_fifo u_fifo (
        .clk   (clk),
        .reset (reset),
        .frame (u_frame_if.fifo_sink),
        .host  (u_fifo_if.store)
    );

endmodule

`default_nettype wire

// ==== tb_uart.sv ====
/*
    Testbench for uart_top
    Clock, reset, case file reader, LFSR byte source
    Bit-banged frame injector, serial monitor on tx, compare task
*/
`timescale 1ns/1ps
`default_nettype none
`include "uart_settings.svh"

module tb_uart;
    import uart_pkg::*;

    localparam int CPB     = `UART_CLKS_PER_BIT;
    localparam int TIMEOUT = 20 * CPB;               // Clocks per bounded wait

    logic       clk;
    logic       reset;
    host_op_t   op;
    logic       op_valid;
    logic [7:0] wdata;
    logic [7:0] rdata;
    logic       rdata_valid;
    logic       tx_busy;
    logic       rx_empty;
    logic       parity_err;
    logic       frame_err;
    logic       overrun;
    logic       tx;
    logic       dut_rx;
    logic       inj_sel;                             // 1 selects injector, 0 loopback
    logic       inj_line;                            // Injector serial level
    logic [2:0] flags;
    logic [31:0] lfsr;
    int         errors;
    int         ncases;
    int         nfailed;

    assign dut_rx = inj_sel ? inj_line : tx;
    assign flags  = {overrun, frame_err, parity_err};

    uart_top u_dut (
        .clk         (clk),
        .reset       (reset),
        .op          (op),
        .op_valid    (op_valid),
        .wdata       (wdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .tx_busy     (tx_busy),
        .rx_empty    (rx_empty),
        .parity_err  (parity_err),
        .frame_err   (frame_err),
        .overrun     (overrun),
        .rx          (dut_rx),
        .tx          (tx)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;                       // 10 ns period
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_byte(output logic [7:0] b);
        int i;
        for (i = 0; i < 8; i++)
        begin
            lfsr = lfsr_step(lfsr);                  // One step per bit
            b[i] = lfsr[0];
        end
    endtask

    task automatic check(input string name, input string what,
                         input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act)
        begin
            $display("** Error: %s %s expected %0h actual %0h", name, what, exp, act);
            errors++;
        end
    endtask

    // Polls one condition per clock until it holds or the timeout expires
    task automatic wait_for(input int which, input string what, output bit ok);
        int n;
        bit hit;
        n   = 0;
        hit = 1'b0;
        while (!hit && n < TIMEOUT)
        begin
            @(posedge clk);
            #1;
            case (which)
                0:       hit = !rx_empty;            // Byte stored
                1:       hit = !tx_busy;             // Transmitter idle
                2:       hit = overrun;
                default: hit = !tx;                  // Start bit on the line
            endcase
            n++;
        end
        if (!hit)
        begin
            $display("Timeout: no %s within 20 bit times", what);
            errors++;
        end
        ok = hit;
    endtask

    // One host command, op_valid high for exactly one edge
    task automatic host_op(input host_op_t o, input logic [7:0] d);
        @(posedge clk);
        #1;
        op       = o;
        wdata    = d;
        op_valid = 1'b1;
        @(posedge clk);
        #1;
        op_valid = 1'b0;
        op       = OP_NOP;
    endtask

    task automatic pop_byte(input string name, input logic [7:0] exp_b, input bit expect_valid);
        host_op(OP_POP, 8'h00);
        check(name, "rdata_valid", 32'(expect_valid), 32'(rdata_valid));  // One cycle after op
        if (expect_valid)
            check(name, "rdata", 32'(exp_b), 32'(rdata));
        @(posedge clk);
        #1;
        check(name, "rdata_valid second cycle", 32'd0, 32'(rdata_valid));
    endtask

    // Start, 8 data LSB first, parity, stop, then one idle bit
    task automatic inject(input logic [7:0] b, input bit bad_par, input bit bad_stop);
        logic [10:0] fr;
        int i;
        fr = {~bad_stop, (^b ^ `UART_PARITY_ODD) ^ bad_par, b, 1'b0};
        for (i = 0; i < 12; i++)
        begin
            @(posedge clk);
            #1;
            inj_line = (i < 11) ? fr[i] : 1'b1;
            repeat (CPB - 1) @(posedge clk);
        end
    endtask

    // Samples tx at the middle of each bit of one frame
    task automatic watch_frame(input string name, input logic [7:0] exp_b);
        logic [10:0] bits;
        bit ok;
        int i;
        wait_for(3, "start bit on tx", ok);
        if (ok)
        begin
            for (i = 0; i < 11; i++)
            begin
                repeat ((i == 0) ? CPB / 2 : CPB) @(posedge clk);
                #1;
                bits[i] = tx;
            end
            check(name, "start bit", 32'd0, 32'(bits[0]));
            check(name, "serial data", 32'(exp_b), 32'(bits[8:1]));
            check(name, "parity bit", 32'(^exp_b ^ `UART_PARITY_ODD), 32'(bits[9]));
            check(name, "stop bit", 32'd1, 32'(bits[10]));
        end
    endtask

    task automatic run_case(input string line);
        string      mode_s;
        string      byte_s;
        string      exp_s;
        string      name;
        logic [7:0] m;
        logic [7:0] b;
        logic [7:0] exp_b;
        logic [2:0] exp_flags;
        int         r;
        int         i;
        int         start_err;
        bit         ok;
        bit         extra;
        start_err = errors;
        r = $sscanf(line, "%s %s %s %h", mode_s, byte_s, exp_s, exp_flags);
        m = (r == 4) ? mode_s.getc(0) : 8'h3f;      // Malformed line falls to default
        b = 8'h00;
        if (byte_s == "R")
            rand_byte(b);
        else
            r = $sscanf(byte_s, "%h", b);
        exp_b = b;
        if (exp_s != "=")
            r = $sscanf(exp_s, "%h", exp_b);
        ncases++;
        name = $sformatf("case %0d (%s %02h)", ncases, mode_s, b);
        inj_sel = (m == "L" || m == "B") ? 1'b0 : 1'b1;
        case (m)
            "L":
            begin
                fork
                    host_op(OP_SEND, b);
                    watch_frame(name, exp_b);
                join
                wait_for(0, "received byte", ok);
                if (ok)
                    pop_byte(name, exp_b, 1'b1);
                check(name, "flags", 32'(exp_flags), 32'(flags));
            end
            "P", "F":
            begin
                inject(b, m == "P", m == "F");
                wait_for(0, "received byte", ok);
                check(name, "flags", 32'(exp_flags), 32'(flags));
                if (ok)
                    pop_byte(name, exp_b, 1'b1);     // Errored byte still stored
            end
            "O":
            begin
                for (i = 0; i < 5; i++)
                    inject(b + 8'(i), 1'b0, 1'b0);   // Fifth one has no room
                wait_for(2, "overrun flag", ok);
                check(name, "flags", 32'(exp_flags), 32'(flags));
                for (i = 0; i < 4; i++)
                    pop_byte(name, exp_b + 8'(i), 1'b1);
                pop_byte(name, 8'h00, 1'b0);         // FIFO drained
            end
            "B":
            begin
                host_op(OP_SEND, b);
                check(name, "tx_busy after send", 32'd1, 32'(tx_busy));
                host_op(OP_SEND, ~b);                // Must be dropped
                wait_for(0, "received byte", ok);
                if (ok)
                    pop_byte(name, exp_b, 1'b1);
                wait_for(1, "transmitter idle", ok);
                extra = 1'b0;
                repeat (15 * CPB)
                begin
                    @(posedge clk);
                    #1;
                    if (!rx_empty)
                        extra = 1'b1;
                end
                check(name, "second frame received", 32'd0, 32'(extra));
                check(name, "flags", 32'(exp_flags), 32'(flags));
            end
            default:
            begin
                $display("Unusable case line: %s", line);
                errors++;
            end
        endcase
        wait_for(1, "transmitter idle", ok);
        host_op(OP_CLEAR, 8'h00);
        check(name, "flags after clear", 32'd0, 32'(flags));  // Zero one cycle later
        if (errors != start_err)
            nfailed++;
        $display("%s: %s", name, (errors == start_err) ? "ok" : "FAILED");
    endtask

    initial
    begin
        int    fd;
        int    r;
        string line;
        errors   = 0;
        ncases   = 0;
        nfailed  = 0;
        lfsr     = 32'd99008;                        // Seed
        reset    = 1'b1;
        op       = OP_NOP;
        op_valid = 1'b0;
        wdata    = 8'h00;
        inj_sel  = 1'b1;                             // Keeps rx high until tx is defined
        inj_line = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        fd = $fopen("uart_cases.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open uart_cases.txt");
            errors++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                r = $fgets(line, fd);
                if (r > 0 && line.len() > 2 && line.getc(0) != "#")
                    run_case(line);
            end
            $fclose(fd);
        end
        $display("Cases run %0d, failed %0d, check errors %0d", ncases, nfailed, errors);
        if (errors == 0 && ncases > 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== uart_cases.txt ====
# mode byte expected flags; L loopback, P bad parity, F bad stop, O overrun, B busy drop
# byte R comes from the LFSR, expected = means the sent byte, flags hex {overrun,frame,parity}
L 55 55 0
L a5 = 0
L 00 00 0
L ff ff 0
L 01 = 0
L 80 = 0
L R = 0
L R = 0
P 3c 3c 1
P R = 1
F c3 c3 2
F R = 2
O 10 10 4
O R = 4
B 5a 5a 0
B R = 0
L R = 0

// ==== src.f ====
+incdir+.
uart_pkg.sv
uart_if.sv
uart_tx.sv
uart_rx.sv
rx_fifo.sv
uart_ctrl.sv
uart_top.sv
tb_uart.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the UART testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module tb_uart -o sim_uart
./obj_dir/sim_uart | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "Test failed, see sim.log"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "Simulation ended without a result line, see sim.log"
    exit 1
fi
echo "Test passed"
